/* flist.f */
logic/colmix_pkg.sv
logic/palette_ram.sv
logic/layer_priority.sv
logic/palette_fetch.sv
logic/blank_delay.sv
logic/colmix_top.sv
tests/tb_clkgen.sv
tests/colmix_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the colour mixer testbench with Verilator, once per game
cd "$(dirname "$0")" || exit 1

for game in 0 1; do
    mdir="obj_dir_game${game}"
    if ! verilator --binary --timing --assert -f flist.f --top-module colmix_tb \
            -GGAME="${game}" -Mdir "${mdir}"; then
        echo "Build failed for GAME=${game}"
        exit 1
    fi
    if ! out=$("./${mdir}/Vcolmix_tb"); then
        printf '%s\n' "${out}"
        echo "Simulation exited with an error for GAME=${game}"
        exit 1
    fi
    printf '%s\n' "${out}"
    if ! printf '%s\n' "${out}" | grep -qx "STATUS: PASS"; then
        echo "Tests failed for GAME=${game}"
        exit 1
    fi
done

echo "Both games passed"
exit 0

/* tests/colmix_tb.sv */
// --------------------------------------------------------------------------
// Directed tests for the colour mixer, one build per GAME value
// Inputs change on the falling edge, pxl_cen every second clk
// Colour checks wait 8 strobes, above the BLANK_DLY+3 latency
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module colmix_tb #(
    parameter int GAME      = colmix_pkg::GAME_CONTRA,
    parameter int BLANK_DLY = 3
);
    import colmix_pkg::*;

    localparam int NUM_PAIRS = 64;
    // Clk budget per test, in run order
    localparam int TEST_CLKS = 200 + (256 + NUM_PAIRS * 16 + 64) + 200 + 136 + 120;
    localparam int MAX_CLKS  = 2 * TEST_CLKS;

    logic         clk;
    logic         rst;
    logic         pxl_cen = 1'b0;
    cpu_bus_t     cpu;
    logic [7:0]   pal_dout;
    gfx_pxl_t     gfx1;
    gfx_pxl_t     gfx2;
    logic         prio_latch;
    video_blank_t blank_in;
    video_blank_t blank_out;
    rgb_t         rgb;
    logic [7:0]   shadow [256];         // Expected palette contents
    logic [31:0]  lfsr   = 32'h28ce60e2;
    int           errors = 0;
    int           cycles = 0;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    colmix_top #(
        .GAME      (GAME),
        .BLANK_DLY (BLANK_DLY)
    ) u_colmix_top (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .cpu        (cpu),
        .pal_dout   (pal_dout),
        .gfx1       (gfx1),
        .gfx2       (gfx2),
        .prio_latch (prio_latch),
        .blank_in   (blank_in),
        .blank_out  (blank_out),
        .rgb        (rgb)
    );

    // Pixel strobe, one clk in two
    always @(negedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CLKS) begin
            $display("Timeout: tests still running after %0d clks", MAX_CLKS);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};    // One step per bit
            lfsr = lfsr_step(lfsr);
        end
        return val;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_blank(input string name, input video_blank_t exp,
                               input video_blank_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Returns on the falling edge right after a strobe
    task automatic next_strobe;
        @(posedge clk);
        while (pxl_cen !== 1'b1) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        cpu = '{cs: 1'b1, rnw: 1'b0, cen: 1'b1, addr: addr, dout: data};
        shadow[addr] = data;
        @(negedge clk);
        cpu.cs  = 1'b0;                 // Bus idle between accesses
        cpu.cen = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [7:0] addr);
        cpu = '{cs: 1'b1, rnw: 1'b1, cen: 1'b1, addr: addr, dout: 8'h00};
        @(negedge clk);                 // Data due one clk later
        check_byte(name, shadow[addr], pal_dout);
        cpu.cs  = 1'b0;
        cpu.cen = 1'b0;
    endtask

    // Even byte is high, its bit 7 dropped
    function automatic rgb_t colour_of(input logic [6:0] idx);
        rgb_t c;
        c = {shadow[{idx, 1'b0}][6:0], shadow[{idx, 1'b1}]};
        return c;
    endfunction

    function automatic logic [6:0] expected_index(input gfx_pxl_t p1, input gfx_pxl_t p2,
                                                  input logic latch);
        logic two_wins;
        logic aux;
        logic other;
        if (GAME == GAME_CONTRA) begin
            two_wins = (p1.code == 4'h0) || !p2.prio;
            return two_wins ? p2 : p1;
        end
        aux      = (p2.code != 4'h0) && p1.prio;
        other    = !(((p1.code == 4'h0) || !p2.prio) && !latch);
        two_wins = !(other && !(aux && latch));
        return two_wins ? {1'b1, p2[5:0]} : {1'b0, p1[5:0]};   // Select replaces bank
    endfunction

    task automatic test_cpu_rw;
        logic [7:0]  addrs [64];
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            r        = rand_bits(16);
            addrs[i] = r[15:8];
            cpu_write(r[15:8], r[7:0]);
        end
        for (int i = 0; i < 64; i++) begin
            read_check("test_cpu_rw", addrs[i]);
        end
    endtask

    task automatic test_priority(input string name);
        logic [31:0] r;
        for (int a = 0; a < 256; a++) begin
            r = rand_bits(8);
            cpu_write(8'(a), r[7:0]);
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            r          = rand_bits(15);
            gfx1       = r[14:8];
            gfx2       = r[7:1];
            prio_latch = r[0];
            repeat (8) next_strobe();
            check_rgb(name, colour_of(expected_index(gfx1, gfx2, prio_latch)), rgb);
        end
    endtask

    task automatic test_transparent;
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r          = rand_bits(15);
            gfx1       = r[14:8];
            gfx2       = r[7:1];
            prio_latch = r[0];
            if (i < 4) begin            // Layer 1 clear first
                gfx1.code = 4'h0;
                gfx2.code = gfx2.code | 4'h1;
            end else begin
                gfx1.code = gfx1.code | 4'h1;
                gfx2.code = 4'h0;
            end
            repeat (8) next_strobe();
            check_rgb("test_transparent",
                      colour_of(expected_index(gfx1, gfx2, prio_latch)), rgb);
        end
    endtask

    task automatic test_blank;
        video_blank_t hist [$];         // Blank values taken at each strobe
        video_blank_t exp_blk;
        rgb_t         col;
        logic [31:0]  r;
        r          = rand_bits(15);
        gfx1       = r[14:8];
        gfx2       = r[7:1];
        prio_latch = r[0];
        blank_in   = 2'b11;
        repeat (8) next_strobe();
        col = colour_of(expected_index(gfx1, gfx2, prio_latch));
        for (int i = 0; i < BLANK_DLY; i++) begin
            hist.push_back(2'b11);
        end
        for (int k = 0; k < 24; k++) begin
            blank_in.lhbl = !((k >= 2 && k <= 5) || (k >= 15 && k <= 16));
            blank_in.lvbl = !((k >= 9 && k <= 12) || (k >= 16 && k <= 17));
            next_strobe();
            hist.push_back(blank_in);
            exp_blk = hist[hist.size() - BLANK_DLY];
            check_blank("test_blank", exp_blk, blank_out);
            check_rgb("test_blank", (exp_blk.lhbl && exp_blk.lvbl) ? col : '0, rgb);
        end
    endtask

    task automatic test_palette_update;
        logic [31:0] r;
        logic [6:0]  idx;
        r          = rand_bits(15);
        gfx1       = r[14:8];
        gfx2       = r[7:1];
        prio_latch = r[0];
        repeat (8) next_strobe();
        idx = expected_index(gfx1, gfx2, prio_latch);
        // Inverted bytes so the new colour always differs
        cpu_write({idx, 1'b0}, ~shadow[{idx, 1'b0}]);
        cpu_write({idx, 1'b1}, ~shadow[{idx, 1'b1}]);
        repeat (8) next_strobe();
        check_rgb("test_palette_update", colour_of(idx), rgb);
    endtask

    initial begin
        cpu        = '0;
        cpu.rnw    = 1'b1;
        gfx1       = '0;
        gfx2       = '0;
        prio_latch = 1'b0;
        blank_in   = 2'b11;             // Display active
        wait (rst == 1'b0);
        @(negedge clk);
        test_cpu_rw();
        if (GAME == GAME_COMBAT) begin
            test_priority("test_priority_combat");
        end else begin
            test_priority("test_priority_contra");
        end
        test_transparent();
        test_blank();
        test_palette_update();
        $display("Tests done for GAME=%0d, errors: %0d", GAME, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tests/tb_clkgen.sv */
// --------------------------------------------------------------------------
// Clock and reset source for the colour mixer testbench
// 20 ns clock, rst high for the first 2 rising edges
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;                // Negedge logic still sees reset on this edge
    end

endmodule

/* logic/colmix_top.sv */
// --------------------------------------------------------------------------
// Colour mixer top level, layer priority into palette into blanking
// CPU and pixel sides share clk, pxl_cen is one clk in two
// Colour latency up to BLANK_DLY+3 strobes, blanking exactly BLANK_DLY
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module colmix_top #(
    parameter int GAME      = colmix_pkg::GAME_CONTRA,
    parameter int BLANK_DLY = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    // CPU
    input  colmix_pkg::cpu_bus_t     cpu,
    output logic [7:0]               pal_dout,
    // Graphics layers
    input  colmix_pkg::gfx_pxl_t     gfx1,
    input  colmix_pkg::gfx_pxl_t     gfx2,
    input  logic                     prio_latch,    // Combat School only
    // Video
    input  colmix_pkg::video_blank_t blank_in,
    output colmix_pkg::video_blank_t blank_out,
    output colmix_pkg::rgb_t         rgb
);
    import colmix_pkg::*;

    logic [6:0]        pal_index;       // Winning layer index
    logic [PAL_AW-1:0] pix_addr;        // Index plus half bit
    logic [7:0]        pix_data;
    rgb_t              colour;          // One colour per pixel

    layer_priority #(
        .GAME (GAME)
    ) u_priority (
        .gfx1       (gfx1),
        .gfx2       (gfx2),
        .prio_latch (prio_latch),
        .pal_index  (pal_index)
    );

    palette_ram u_ram (
        .clk      (clk),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

    palette_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pal_index (pal_index),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .colour    (colour)
    );

    blank_delay #(
        .BLANK_DLY (BLANK_DLY)
    ) u_blank (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .blank_in  (blank_in),
        .colour_in (colour),
        .blank_out (blank_out),
        .rgb       (rgb)
    );

endmodule

/* logic/blank_delay.sv */
// --------------------------------------------------------------------------
// Delays colour and blanking by BLANK_DLY pixel strobes
// Colour is black while either delayed blank bit is low
// Outputs read as blanked after reset, BLANK_DLY must be at least 1
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module blank_delay #(
    parameter int BLANK_DLY = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  colmix_pkg::video_blank_t blank_in,
    input  colmix_pkg::rgb_t         colour_in,
    output colmix_pkg::video_blank_t blank_out,
    output colmix_pkg::rgb_t         rgb
);
    import colmix_pkg::*;

    video_blank_t blk_pipe [BLANK_DLY];
    rgb_t         col_pipe [BLANK_DLY];
    logic         visible;              // Both delayed blanks inactive

    // Blanking stages, cleared to blanked
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BLANK_DLY; i++) begin
                blk_pipe[i] <= '0;
            end
        end else if (pxl_cen) begin
            blk_pipe[0] <= blank_in;
            for (int i = 1; i < BLANK_DLY; i++) begin
                blk_pipe[i] <= blk_pipe[i-1];
            end
        end
    end

    // Colour stages move in step with blanking
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            col_pipe[0] <= colour_in;
            for (int i = 1; i < BLANK_DLY; i++) begin
                col_pipe[i] <= col_pipe[i-1];
            end
        end
    end

    assign blank_out = blk_pipe[BLANK_DLY-1];
    assign visible   = blank_out.lhbl & blank_out.lvbl;
    assign rgb       = visible ? col_pipe[BLANK_DLY-1] : '0;

    generate
        if (BLANK_DLY < 1) begin : g_bad_dly
            $error("blank_delay: BLANK_DLY must be 1 or more");
        end
    endgenerate

endmodule

/* logic/palette_fetch.sv */
// --------------------------------------------------------------------------
// Reads the two palette bytes of a pixel and latches one colour per pixel
// Expects pxl_cen one clk in two, phase settles after the first strobe
// Colour of a pixel appears at the second strobe after it is presented
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module palette_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic [6:0]                    pal_index,
    output logic [colmix_pkg::PAL_AW-1:0] pix_addr,
    input  logic [7:0]                    pix_data,
    output colmix_pkg::rgb_t              colour
);
    import colmix_pkg::*;

    logic        half;                  // Low on strobe clks, high otherwise
    logic [15:0] pair;                  // High byte then low byte

    // Even address holds the high byte
    assign pix_addr = {pal_index, half};

    always_ff @(posedge clk) begin
        if (rst) begin
            half <= 1'b0;
        end else if (pxl_cen) begin
            half <= 1'b1;
        end else begin
            half <= ~half;
        end
    end

    // Odd byte arrives first, even byte pushes it down from the top
    always_ff @(posedge clk) begin
        pair <= {pix_data, pair[15:8]};
        if (pxl_cen) begin
            colour <= rgb_t'(pair[14:0]);   // Bit 15 unused
        end
    end

    // Two-clk pixel period is what keeps the half bit in phase
    a_cen_spacing : assert property (
        @(posedge clk) disable iff (rst) pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high on consecutive clks");

endmodule

/* logic/layer_priority.sv */
// --------------------------------------------------------------------------
// Picks one of two graphics layers per pixel and forms the palette index
// Purely combinational, inputs held for the whole pixel period
// GAME selects the board rule, Combat School also uses prio_latch
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module layer_priority #(
    parameter int GAME = colmix_pkg::GAME_CONTRA
) (
    input  colmix_pkg::gfx_pxl_t gfx1,
    input  colmix_pkg::gfx_pxl_t gfx2,
    input  logic                 prio_latch,
    output logic [6:0]           pal_index
);
    import colmix_pkg::*;

    logic     gfx1_clear;               // Layer 1 transparent
    logic     gfx2_clear;               // Layer 2 transparent
    logic     sel;                      // High picks layer 2
    gfx_pxl_t win;

    assign gfx1_clear = gfx1.code == 4'h0;
    assign gfx2_clear = gfx2.code == 4'h0;
    assign win        = sel ? gfx2 : gfx1;

    generate
        if (GAME == GAME_COMBAT) begin : g_combat
            logic aux;                  // Layer 1 wants to sit over layer 2
            logic other;

            assign aux   = ~gfx2_clear & gfx1.prio;
            assign other = ~((gfx1_clear | ~gfx2.prio) & ~prio_latch);
            assign sel   = ~(other & ~(aux & prio_latch));

            // Select bit replaces the bank bit
            assign pal_index = {sel, win[5:0]};
        end else begin : g_contra
            // Layer 2 shows through a clear layer 1 or when it has no prio
            assign sel       = gfx1_clear | ~gfx2.prio;
            assign pal_index = win;     // Full 7 bits of the winner
        end
    endgenerate

    // Only the two board rules exist
    generate
        if (GAME != GAME_CONTRA && GAME != GAME_COMBAT) begin : g_bad_game
            $error("layer_priority: GAME must be GAME_CONTRA or GAME_COMBAT");
        end
    endgenerate

endmodule

/* logic/palette_ram.sv */
// --------------------------------------------------------------------------
// 256x8 palette RAM, CPU read/write port plus read-only pixel port
// Both reads are registered, data one clk after the address
// A CPU read of the byte being written returns the old value
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module palette_ram (
    input  logic                          clk,
    input  colmix_pkg::cpu_bus_t          cpu,
    output logic [7:0]                    pal_dout,
    input  logic [colmix_pkg::PAL_AW-1:0] pix_addr,
    output logic [7:0]                    pix_data
);
    import colmix_pkg::*;

    logic [7:0] mem [2**PAL_AW];    // Two bytes per colour
    logic       we;

    // Single-cycle write strobe from the bus fields
    assign we = cpu.cs & cpu.cen & ~cpu.rnw;

    // CPU port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[cpu.addr] <= cpu.dout;
        end
        pal_dout <= mem[cpu.addr];  // Read-before-write
    end

    // Pixel port, read only
    always_ff @(posedge clk) begin
        pix_data <= mem[pix_addr];
    end

    // Write must target a known byte or the palette is corrupted silently
    a_write_addr_known : assert property (
        @(posedge clk) we |-> !$isunknown(cpu.addr)
    ) else $error("palette write with unknown address");

endmodule

/* logic/colmix_pkg.sv */
// --------------------------------------------------------------------------
// Shared types and constants for the colour mixer
// Struct fields are listed top bit first, as they sit on the wire
// GAME accepts only the two game codes below
// --------------------------------------------------------------------------
package colmix_pkg;

    // Legal values of the GAME parameter
    localparam int GAME_CONTRA = 0;     // Contra priority rule
    localparam int GAME_COMBAT = 1;     // Combat School rule, uses prio latch

    localparam int PAL_AW = 8;          // 256 palette bytes, two per colour

    // Pixel from one graphics layer
    typedef struct packed {
        logic       bank;               // Palette bank
        logic       group;              // Colour group within bank
        logic       prio;               // Layer priority flag
        logic [3:0] code;               // Zero means transparent
    } gfx_pxl_t;

    // 15-bit BGR colour
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // CPU access to the palette
    typedef struct packed {
        logic       cs;                 // Palette chip select
        logic       rnw;                // High for read
        logic       cen;                // Bus cycle enable
        logic [7:0] addr;
        logic [7:0] dout;               // Write data from CPU
    } cpu_bus_t;

    // Blanking, both active low
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } video_blank_t;

endpackage
